// File: Makefile
# Verilator build and run of the ring bus mediator testbench

VERILATOR ?= verilator
TOP       ?= ulpb_tb
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "Errors found" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: flist.f
hdl/ulpb_bus_pkg.sv
hdl/ulpb_cfg_pkg.sv
hdl/ulpb_ctrl.sv
hdl/ulpb_ctrl_regs.sv
hdl/ulpb_top.sv
verif/ulpb_tb.sv

// File: hdl/ulpb_bus_pkg.sv
/* ring bus state and control bit definitions */

package ulpb_bus_pkg;

	// mediator states, encodings fixed by the ring protocol
	typedef enum logic [3:0]
	{
		BUS_IDLE         = 4'd0,
		BUS_ARBITRATE    = 4'd1,
		BUS_PRIO         = 4'd2,
		BUS_WAIT_START   = 4'd3,
		BUS_START        = 4'd4,
		BUS_ACTIVE       = 4'd5,
		BUS_SWITCH_ROLE  = 4'd6,
		BUS_INTERRUPT    = 4'd7,
		BUS_CONTROL0     = 4'd8,
		BUS_CONTROL1     = 4'd9,
		BUS_BACK_TO_IDLE = 4'd10
	} bus_state_t;

	// positions inside the 2-bit control sequence
	localparam int CTRL_EOM_BIT  = 1;	// end of message
	localparam int CTRL_NACK_BIT = 0;	// not acknowledge

endpackage

// File: hdl/ulpb_cfg_pkg.sv
/* mediator config register map */

package ulpb_cfg_pkg;

	localparam int CFG_ADDR_W = 2;
	localparam int CFG_DATA_W = 16;

	localparam logic [CFG_ADDR_W-1:0] ADDR_THRESHOLD = 2'd0;
	localparam logic [CFG_ADDR_W-1:0] ADDR_CONTROL   = 2'd1;
	localparam logic [CFG_ADDR_W-1:0] ADDR_WD_COUNT  = 2'd2;	// write clears
	// address 3 is unmapped and reads zero

endpackage

// File: hdl/ulpb_ctrl.sv
/* ring bus mediator controller */

`timescale 1ns/1ps

module ulpb_ctrl
#(
	parameter int WATCH_DOG_WIDTH  = 8,
	parameter int START_CYCLES     = 10,
	parameter int INTERRUPT_CYCLES = 6
)
(
	input  logic                       CLK_EXT,
	input  logic                       RESETn,
	input  logic                       clkin,
	input  logic                       din,
	input  logic [WATCH_DOG_WIDTH-1:0] threshold,
	input  logic [1:0]                 ctrl_seq,
	output logic                       clkout,
	output logic                       dout,
	output logic                       wd_expired
);

	import ulpb_bus_pkg::*;

	localparam int START_W = $clog2(START_CYCLES + 1);
	localparam int INT_W   = $clog2(INTERRUPT_CYCLES + 1);

	bus_state_t bus_state, next_bus_state;
	bus_state_t bus_state_neg;	// selects dout

	logic [START_W-1:0]         start_cnt, next_start_cnt;
	logic [INT_W-1:0]           int_cnt, next_int_cnt;
	logic [WATCH_DOG_WIDTH-1:0] wd_cnt, next_wd_cnt;
	logic                       clk_en, next_clk_en;

	logic       clkin_sampled;
	logic [2:0] din_sampled_pos;
	logic [2:0] din_sampled_neg;

	assign clkout = clk_en ? CLK_EXT : 1'b1;	// parks high when off

	// active phase ends on the watchdog
	assign wd_expired = (bus_state == BUS_ACTIVE) && (wd_cnt == threshold);

	always_ff @(posedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			bus_state <= BUS_IDLE;
			start_cnt <= START_W'(START_CYCLES - 1);
			int_cnt   <= INT_W'(INTERRUPT_CYCLES - 1);
			wd_cnt    <= '0;
			clk_en    <= 1'b0;
		end
		else
		begin
			bus_state <= next_bus_state;
			start_cnt <= next_start_cnt;
			int_cnt   <= next_int_cnt;
			wd_cnt    <= next_wd_cnt;
			clk_en    <= next_clk_en;
		end
	end

	always_comb
	begin
		next_bus_state = bus_state;
		next_start_cnt = start_cnt;
		next_int_cnt   = int_cnt;
		next_wd_cnt    = wd_cnt;
		next_clk_en    = clk_en;

		case (bus_state)
			BUS_IDLE:
			begin
				if (!din)
					next_bus_state = BUS_WAIT_START;
				next_start_cnt = START_W'(START_CYCLES - 1);
				next_wd_cnt    = '0;
			end

			BUS_WAIT_START:
			begin
				if (start_cnt != '0)
					next_start_cnt = start_cnt - 1'b1;
				else
				begin
					next_clk_en    = 1'b1;
					next_bus_state = BUS_START;
				end
			end

			BUS_START:
				next_bus_state = BUS_ARBITRATE;

			BUS_ARBITRATE:
			begin
				next_bus_state = BUS_PRIO;
				if (din)
					next_wd_cnt = threshold;	// glitch, cut active short
			end

			BUS_PRIO:
				next_bus_state = BUS_ACTIVE;

			BUS_ACTIVE:
			begin
				if ((wd_cnt < threshold) && !clkin_sampled)
					next_wd_cnt = wd_cnt + 1'b1;
				else
				begin
					next_clk_en    = 1'b0;
					next_bus_state = BUS_INTERRUPT;
				end
				next_int_cnt = INT_W'(INTERRUPT_CYCLES - 1);
			end

			BUS_INTERRUPT:
			begin
				if (int_cnt != '0)
					next_int_cnt = int_cnt - 1'b1;
				else if ({din_sampled_neg, din_sampled_pos} == 6'b111_000)
				begin
					// release pattern seen
					next_clk_en    = 1'b1;
					next_bus_state = BUS_SWITCH_ROLE;
				end
			end

			BUS_SWITCH_ROLE:
				next_bus_state = BUS_CONTROL0;

			BUS_CONTROL0:
				next_bus_state = BUS_CONTROL1;

			BUS_CONTROL1:
				next_bus_state = BUS_BACK_TO_IDLE;

			BUS_BACK_TO_IDLE:
			begin
				if (!din)
				begin
					next_bus_state = BUS_WAIT_START;	// next request already pending
					next_start_cnt = START_W'(1);
				end
				else
					next_bus_state = BUS_IDLE;
				next_clk_en = 1'b0;
				next_wd_cnt = '0;
			end

			default:
				next_bus_state = BUS_IDLE;
		endcase
	end

	always_ff @(posedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			clkin_sampled   <= 1'b0;
			din_sampled_pos <= '0;
		end
		else
		begin
			clkin_sampled <= clkin;
			if (bus_state == BUS_INTERRUPT)
				din_sampled_pos <= {din_sampled_pos[1:0], din};
		end
	end

	always_ff @(negedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			din_sampled_neg <= '0;
			bus_state_neg   <= BUS_IDLE;
		end
		else
		begin
			if (bus_state == BUS_INTERRUPT)
				din_sampled_neg <= {din_sampled_neg[1:0], din};
			bus_state_neg <= bus_state;
		end
	end

	always_comb
	begin
		dout = din;	// pass through by default
		case (bus_state_neg)
			BUS_IDLE, BUS_WAIT_START, BUS_START, BUS_BACK_TO_IDLE:
				dout = 1'b1;
			BUS_INTERRUPT:
				dout = CLK_EXT;
			BUS_CONTROL0:
				if (wd_cnt == threshold)
					dout = ~ctrl_seq[CTRL_EOM_BIT];
			default:
				dout = din;
		endcase
	end

	wd_pulse_single: assert property (@(posedge CLK_EXT) disable iff (!RESETn)
		wd_expired |=> !wd_expired);

	state_in_range: assert property (@(posedge CLK_EXT) disable iff (!RESETn)
		(bus_state <= BUS_BACK_TO_IDLE) && (bus_state_neg <= BUS_BACK_TO_IDLE));

	wd_cnt_bounded: assert property (@(posedge CLK_EXT) disable iff (!RESETn)
		(bus_state == BUS_ACTIVE) |-> (wd_cnt <= threshold));

endmodule

// File: hdl/ulpb_ctrl_regs.sv
/* mediator config registers */

`timescale 1ns/1ps

module ulpb_ctrl_regs
#(
	parameter int                         WATCH_DOG_WIDTH = 8,
	parameter logic [WATCH_DOG_WIDTH-1:0] THRESHOLD_RESET = 8'h20
)
(
	input  logic                              CLK_EXT,
	input  logic                              RESETn,
	input  logic                              cfg_wr,
	input  logic [ulpb_cfg_pkg::CFG_ADDR_W-1:0] cfg_addr,
	input  logic [ulpb_cfg_pkg::CFG_DATA_W-1:0] cfg_wdata,
	input  logic                              wd_expired,
	output logic [ulpb_cfg_pkg::CFG_DATA_W-1:0] cfg_rdata,
	output logic [WATCH_DOG_WIDTH-1:0]        threshold,
	output logic [1:0]                        ctrl_seq
);

	import ulpb_cfg_pkg::*;
	import ulpb_bus_pkg::*;

	logic [WATCH_DOG_WIDTH-1:0] wd_count;

	always_ff @(posedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			threshold <= THRESHOLD_RESET;
			ctrl_seq  <= 2'b00;
			wd_count  <= '0;
		end
		else
		begin
			if (cfg_wr && (cfg_addr == ADDR_THRESHOLD))
				threshold <= cfg_wdata[WATCH_DOG_WIDTH-1:0];
			if (cfg_wr && (cfg_addr == ADDR_CONTROL))
			begin
				ctrl_seq[CTRL_EOM_BIT]  <= cfg_wdata[CTRL_EOM_BIT];
				ctrl_seq[CTRL_NACK_BIT] <= cfg_wdata[CTRL_NACK_BIT];
			end
			if (cfg_wr && (cfg_addr == ADDR_WD_COUNT))
				wd_count <= '0;	// clear beats a same-cycle expiry
			else if (wd_expired && (wd_count != '1))
				wd_count <= wd_count + 1'b1;	// saturates
		end
	end

	always_comb
	begin
		case (cfg_addr)
			ADDR_THRESHOLD: cfg_rdata = CFG_DATA_W'(threshold);
			ADDR_CONTROL:   cfg_rdata = CFG_DATA_W'(ctrl_seq);
			ADDR_WD_COUNT:  cfg_rdata = CFG_DATA_W'(wd_count);
			default:        cfg_rdata = '0;
		endcase
	end

	thr_write_lands: assert property (@(posedge CLK_EXT) disable iff (!RESETn)
		(cfg_wr && (cfg_addr == ADDR_THRESHOLD))
		|=> (threshold == $past(cfg_wdata[WATCH_DOG_WIDTH-1:0])));

endmodule

// File: hdl/ulpb_top.sv
/* ring bus mediator top */

`timescale 1ns/1ps

module ulpb_top
#(
	parameter int                         WATCH_DOG_WIDTH  = 8,
	parameter int                         START_CYCLES     = 10,
	parameter int                         INTERRUPT_CYCLES = 6,
	parameter logic [WATCH_DOG_WIDTH-1:0] THRESHOLD_RESET  = 8'h20
)
(
	input  logic                              CLK_EXT,
	input  logic                              RESETn,
	input  logic                              clkin,	// ring clock return
	input  logic                              din,	// ring data return
	output logic                              clkout,
	output logic                              dout,
	input  logic                              cfg_wr,
	input  logic [ulpb_cfg_pkg::CFG_ADDR_W-1:0] cfg_addr,
	input  logic [ulpb_cfg_pkg::CFG_DATA_W-1:0] cfg_wdata,
	output logic [ulpb_cfg_pkg::CFG_DATA_W-1:0] cfg_rdata
);

	logic [WATCH_DOG_WIDTH-1:0] threshold;
	logic [1:0]                 ctrl_seq;
	logic                       wd_expired;

	ulpb_ctrl
	#(
		.WATCH_DOG_WIDTH  (WATCH_DOG_WIDTH),
		.START_CYCLES     (START_CYCLES),
		.INTERRUPT_CYCLES (INTERRUPT_CYCLES)
	)
	u_ctrl
	(
		.CLK_EXT    (CLK_EXT),
		.RESETn     (RESETn),
		.clkin      (clkin),
		.din        (din),
		.threshold  (threshold),
		.ctrl_seq   (ctrl_seq),
		.clkout     (clkout),
		.dout       (dout),
		.wd_expired (wd_expired)
	);

	ulpb_ctrl_regs
	#(
		.WATCH_DOG_WIDTH (WATCH_DOG_WIDTH),
		.THRESHOLD_RESET (THRESHOLD_RESET)
	)
	u_regs
	(
		.CLK_EXT    (CLK_EXT),
		.RESETn     (RESETn),
		.cfg_wr     (cfg_wr),
		.cfg_addr   (cfg_addr),
		.cfg_wdata  (cfg_wdata),
		.wd_expired (wd_expired),
		.cfg_rdata  (cfg_rdata),
		.threshold  (threshold),
		.ctrl_seq   (ctrl_seq)
	);

endmodule

// File: verif/ulpb_tb.sv
/* ring bus mediator testbench */

`timescale 1ns/1ps

module ulpb_tb;

	import ulpb_cfg_pkg::*;
	import ulpb_bus_pkg::*;

	localparam int              PERIOD           = 20;
	localparam int              WD_W             = 8;
	localparam int              START_CYCLES     = 10;
	localparam int              INTERRUPT_CYCLES = 6;
	localparam logic [WD_W-1:0] THRESHOLD_RESET  = 8'h20;
	localparam int              N_TXN            = 8;
	localparam logic [31:0]     SEED             = 32'h785e;
	localparam int              WATCHDOG_NS      = N_TXN * (START_CYCLES + 64 + 40) * PERIOD;

	logic                  CLK_EXT, RESETn, clkin, din, clkout, dout, cfg_wr;
	logic [CFG_ADDR_W-1:0] cfg_addr;
	logic [CFG_DATA_W-1:0] cfg_wdata, cfg_rdata, rd_exp;
	logic                  exp_en, exp_high, exp_irq, exp_ctl0, exp_dout, rd_chk;
	logic                  smp_hi = 1'b0;
	logic                  smp_lo = 1'b0;
	logic [31:0]           lfsr;
	int                    errors;
	int                    exp_cnt;

	ulpb_top #(.WATCH_DOG_WIDTH(WD_W), .START_CYCLES(START_CYCLES),
		.INTERRUPT_CYCLES(INTERRUPT_CYCLES), .THRESHOLD_RESET(THRESHOLD_RESET)) dut_i
	(
		.CLK_EXT(CLK_EXT), .RESETn(RESETn), .clkin(clkin), .din(din),
		.clkout(clkout), .dout(dout), .cfg_wr(cfg_wr), .cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata)
	);

	always #(PERIOD / 2) CLK_EXT = ~CLK_EXT;

	// check strobes in the middle of each clock phase
	always @(posedge CLK_EXT)
	begin
		#5 smp_hi = 1'b1;
		#1 smp_hi = 1'b0;
		#9 smp_lo = 1'b1;
		#1 smp_lo = 1'b0;
	end

	function automatic void value_error(string name, logic [15:0] got, logic [15:0] want);
		errors++;
		$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want);
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// taps 32 22 2 1
	endfunction

	clkout_ok: assert property (@(posedge smp_lo) clkout == !exp_en)
		else value_error("clkout", 16'(clkout), 16'(!exp_en));
	dout_high_ok: assert property (@(posedge smp_lo) exp_high |-> dout)
		else value_error("dout", 16'(dout), 16'h1);
	irq_lo_ok: assert property (@(posedge smp_lo) exp_irq |-> (dout == CLK_EXT))
		else value_error("dout", 16'(dout), 16'(CLK_EXT));
	irq_hi_ok: assert property (@(posedge smp_hi) exp_irq |-> (dout == CLK_EXT))
		else value_error("dout", 16'(dout), 16'(CLK_EXT));
	eom_ok: assert property (@(posedge smp_lo) exp_ctl0 |-> (dout == exp_dout))
		else value_error("dout", 16'(dout), 16'(exp_dout));
	rdata_ok: assert property (@(posedge smp_lo) rd_chk |-> (cfg_rdata == rd_exp))
		else value_error("cfg_rdata", cfg_rdata, rd_exp);

	task automatic step();
		@(posedge CLK_EXT);
		#2;
	endtask

	task automatic rand_bits(input int n, output int val);
		int b;
		val = 0;
		for (b = 0; b < n; b++)
		begin
			lfsr = lfsr_next(lfsr);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	task automatic write_reg(input logic [CFG_ADDR_W-1:0] addr,
		input logic [CFG_DATA_W-1:0] data);
		cfg_wr = 1'b1;
		cfg_addr = addr;
		cfg_wdata = data;
		step();
		cfg_wr = 1'b0;
	endtask

	task automatic check_read(input logic [CFG_ADDR_W-1:0] addr,
		input logic [CFG_DATA_W-1:0] value);
		cfg_addr = addr;
		rd_exp = value;
		rd_chk = 1'b1;
		step();
		rd_chk = 1'b0;
	endtask

	// one idle cycle with din low
	task automatic request();
		din = 1'b0;
		step();
	endtask

	task automatic run_txn(input int waits, input int thr, input bit glitch,
		input logic [1:0] ctl, input bit chain);
		int act;
		int hold;
		int nint;
		int j;
		write_reg(ADDR_THRESHOLD, CFG_DATA_W'(thr));
		write_reg(ADDR_CONTROL, CFG_DATA_W'(ctl));
		repeat (waits - 2) step();
		exp_en = 1'b1;	// start
		step();
		exp_high = 1'b0;
		din = glitch;	// sampled in arbitrate
		step();
		din = 1'b1;
		act = glitch ? 1 : thr + 1;
		repeat (act + 1) step();
		exp_en = 1'b0;	// first interrupt cycle
		rand_bits(3, hold);
		nint = (hold + 4 > INTERRUPT_CYCLES) ? hold + 4 : INTERRUPT_CYCLES;
		for (j = 0; j < nint; j++)
		begin
			exp_irq = (j != 0);
			din = 1'b1;
			if (j >= hold)
			begin
				@(negedge CLK_EXT);	// ring echoes the interrupt clock
				#2;
				din = 1'b0;
			end
			step();
		end
		exp_irq = 1'b0;
		exp_en = 1'b1;	// switch_role
		din = 1'b1;
		step();
		exp_ctl0 = 1'b1;
		exp_dout = ~ctl[CTRL_EOM_BIT];
		step();
		exp_ctl0 = 1'b0;
		step();
		exp_high = 1'b1;	// back_to_idle
		din = !chain;
		step();
		exp_en = 1'b0;
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("errors: %0d", errors + 1);
		$display("Errors found");
		$finish;
	end

	initial
	begin
		int t;
		int thr;
		int ctl_r;
		int gap;
		bit glitch;
		bit chain;
		bit chained;
		CLK_EXT = 1'b0;
		RESETn = 1'b0;
		clkin = 1'b0;
		din = 1'b1;
		cfg_wr = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		{exp_en, exp_irq, exp_ctl0, rd_chk} = '0;
		exp_high = 1'b1;
		exp_dout = 1'b1;
		rd_exp = '0;
		lfsr = SEED;
		errors = 0;
		exp_cnt = 0;
		chained = 1'b0;
		repeat (16) @(posedge CLK_EXT);
		#2;
		RESETn = 1'b1;
		check_read(ADDR_THRESHOLD, CFG_DATA_W'(THRESHOLD_RESET));
		check_read(ADDR_CONTROL, '0);
		check_read(ADDR_WD_COUNT, '0);
		check_read(2'd3, '0);
		for (t = 0; t < N_TXN; t++)
		begin
			rand_bits(5, thr);
			thr = thr + 4;
			rand_bits(2, ctl_r);
			glitch = (t % 4 == 3);
			chain = (t % 3 == 1) && (t < N_TXN - 1);
			if (!chained)
				request();
			run_txn(chained ? 2 : START_CYCLES, thr, glitch, ctl_r[1:0], chain);
			exp_cnt++;
			chained = chain;
			if (!chain)
			begin
				rand_bits(3, gap);
				repeat (gap + 1) step();
				check_read(ADDR_THRESHOLD, CFG_DATA_W'(thr));
				check_read(ADDR_CONTROL, CFG_DATA_W'(ctl_r[1:0]));
				check_read(ADDR_WD_COUNT, CFG_DATA_W'(exp_cnt));
				if (t == 3)
				begin
					write_reg(ADDR_WD_COUNT, '0);
					exp_cnt = 0;
					check_read(ADDR_WD_COUNT, '0);
				end
			end
		end
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
